/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = FramebufferWriterTb
FILELIST = sources.f
BUILDDIR = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with $(TOOL), run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILDDIR) and $(LOG)"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILDDIR) -f $(FILELIST)
	-./$(BUILDDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "=== PASS ===" $(LOG); then echo "Simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILDDIR) $(LOG)

/* source/FramebufferPkg.sv */
package FramebufferPkg;

    //////////////////////////////
    // Bus and pixel geometry
    //////////////////////////////
    localparam int StreamWidth = 32;
    localparam int StrbWidth = StreamWidth / 8;
    localparam int AddrWidth = 32;
    localparam int PixelWidth = 16;
    localparam int PixelBytes = PixelWidth / 8;
    localparam int PixelsPerBeat = StreamWidth / PixelWidth;
    localparam int XBitWidth = 11;
    localparam int YBitWidth = 11;

    // Pixel index splits into a line tag and a lane inside the word
    localparam int LaneWidth = $clog2(PixelsPerBeat);
    localparam int TagWidth = AddrWidth - LaneWidth;
    localparam int WordOffsetWidth = $clog2(StrbWidth);

    //////////////////////////////
    // Write master
    //////////////////////////////
    localparam int IdWidth = 8;
    localparam int MaxOutstanding = 4;
    localparam int CountWidth = $clog2(MaxOutstanding + 1);

    // Single beat bursts of one full word
    localparam logic [7:0] BurstLen = 8'd0;
    localparam logic [2:0] BurstSize = 3'(WordOffsetWidth);
    localparam logic [1:0] BurstIncr = 2'b01;

    typedef enum logic [1:0] {
        Idle,
        AddrData,
        AddrOnly,
        DataOnly
    } IssueState;

endpackage

/* source/FramebufferWriter.sv */
`timescale 1ns/100ps

module FramebufferWriter import FramebufferPkg::*;
(
    input  logic                    aclk,
    input  logic                    resetn,

    //////////////////////////////
    // Configuration
    //////////////////////////////
    input  logic [AddrWidth-1:0]    confAddr,
    input  logic                    confEnableScissor,
    input  logic [XBitWidth-1:0]    confScissorStartX,
    input  logic [YBitWidth-1:0]    confScissorStartY,
    input  logic [XBitWidth-1:0]    confScissorEndX,
    input  logic [YBitWidth-1:0]    confScissorEndY,
    input  logic [PixelBytes-1:0]   confMask,

    //////////////////////////////
    // Fragments
    //////////////////////////////
    input  logic                    fragValid,
    output logic                    fragReady,
    input  logic [PixelWidth-1:0]   fragData,
    input  logic                    fragStrobe,
    input  logic [AddrWidth-1:0]    fragAddr,
    input  logic [XBitWidth-1:0]    fragXPos,
    input  logic [YBitWidth-1:0]    fragYPos,
    input  logic                    fragLast,

    //////////////////////////////
    // Memory write master
    //////////////////////////////
    output logic [IdWidth-1:0]      awid,
    output logic [AddrWidth-1:0]    awaddr,
    output logic [7:0]              awlen,
    output logic [2:0]              awsize,
    output logic [1:0]              awburst,
    output logic                    awvalid,
    input  logic                    awready,
    output logic [StreamWidth-1:0]  wdata,
    output logic [StrbWidth-1:0]    wstrb,
    output logic                    wlast,
    output logic                    wvalid,
    input  logic                    wready,
    // Only the B handshake is counted and bid and bresp go unread
    input  logic [IdWidth-1:0]      bid,
    input  logic [1:0]              bresp,
    input  logic                    bvalid,
    output logic                    bready
);
    logic [StrbWidth-1:0] fragByteStrobe;
    logic                 credit;
    logic                 issue;

    LineRequestIf lineReq ();

    assign awlen = BurstLen;
    assign awsize = BurstSize;
    assign awburst = BurstIncr;
    assign wlast = 1'b1;
    assign bready = 1'b1;

    ScissorStrobeGen u_strobeGen (
        .confEnableScissor (confEnableScissor),
        .confScissorStartX (confScissorStartX),
        .confScissorStartY (confScissorStartY),
        .confScissorEndX   (confScissorEndX),
        .confScissorEndY   (confScissorEndY),
        .confMask          (confMask),
        .xPos              (fragXPos),
        .yPos              (fragYPos),
        .pixelStrobe       (fragStrobe),
        .laneSel           (fragAddr[LaneWidth-1:0]),
        .strobe            (fragByteStrobe)
    );

    LineCoalescer u_coalescer (
        .aclk      (aclk),
        .resetn    (resetn),
        .fragValid (fragValid),
        .fragReady (fragReady),
        .fragData  (fragData),
        .fragAddr  (fragAddr),
        .fragLast  (fragLast),
        .strobe    (fragByteStrobe),
        .req       (lineReq.coalescer)
    );

    WriteIssueFsm u_issueFsm (
        .aclk     (aclk),
        .resetn   (resetn),
        .confAddr (confAddr),
        .credit   (credit),
        .awid     (awid),
        .issue    (issue),
        .req      (lineReq.issuer),
        .awaddr   (awaddr),
        .awvalid  (awvalid),
        .awready  (awready),
        .wdata    (wdata),
        .wstrb    (wstrb),
        .wvalid   (wvalid),
        .wready   (wready)
    );

    OutstandingCounter u_outstanding (
        .aclk   (aclk),
        .resetn (resetn),
        .issue  (issue),
        .bvalid (bvalid),
        .bready (bready),
        .credit (credit),
        .awid   (awid)
    );

endmodule

/* source/LineCoalescer.sv */
`timescale 1ns/100ps

module LineCoalescer import FramebufferPkg::*;
(
    input  logic                    aclk,
    input  logic                    resetn,

    input  logic                    fragValid,
    output logic                    fragReady,
    input  logic [PixelWidth-1:0]   fragData,
    input  logic [AddrWidth-1:0]    fragAddr,
    input  logic                    fragLast,
    input  logic [StrbWidth-1:0]    strobe,

    LineRequestIf.coalescer         req
);
    logic [TagWidth-1:0]    fragTag;
    logic [LaneWidth-1:0]   fragLane;
    logic                   fragAccept;
    logic                   sameLine;
    logic                   closeNow;

    // Open line
    logic [TagWidth-1:0]    openTag;
    logic [StreamWidth-1:0] openData;
    logic [StrbWidth-1:0]   openStrb;
    logic                   openOccupied;

    // Fragment parked while the previous line still waits for the issuer
    logic [TagWidth-1:0]    skidTag;
    logic [LaneWidth-1:0]   skidLane;
    logic [PixelWidth-1:0]  skidData;
    logic [StrbWidth-1:0]   skidStrb;
    logic                   skidLast;
    logic                   skidFull;

    assign fragTag = fragAddr[LaneWidth +: TagWidth];
    assign fragLane = fragAddr[LaneWidth-1:0];
    assign fragAccept = fragValid && fragReady;

    // An empty line adopts whatever tag arrives
    assign sameLine = !openOccupied || (fragTag == openTag);

    // Close on a tag change, or while stalled for the skid or the end of stream
    assign closeNow = !req.valid && ((fragAccept && !sameLine) || !fragReady);

    //////////////////////////////
    // Line request
    //////////////////////////////
    always_ff @(posedge aclk)
    begin
        if (!resetn)
            req.valid <= 1'b0;
        else if (req.take)
            req.valid <= 1'b0;
        else if (closeNow)
            // Lines without any enabled byte are dropped here
            req.valid <= openOccupied && (|openStrb);
    end

    always_ff @(posedge aclk)
    begin
        if (closeNow)
        begin
            req.lineAddr <= AddrWidth'({openTag, {WordOffsetWidth{1'b0}}});
            req.data <= openData;
            req.strb <= openStrb;
        end
    end

    //////////////////////////////
    // Open line and skid
    //////////////////////////////
    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            fragReady <= 1'b1;
            openOccupied <= 1'b0;
            openStrb <= '0;
            skidFull <= 1'b0;
        end
        else if (fragReady)
        begin
            if (fragAccept)
            begin
                if (sameLine || !req.valid)
                begin
                    openTag <= fragTag;
                    openData[fragLane*PixelWidth +: PixelWidth] <= fragData;
                    openStrb <= sameLine ? (openStrb | strobe) : strobe;
                    openOccupied <= 1'b1;
                    fragReady <= !fragLast;
                end
                else
                begin
                    skidTag <= fragTag;
                    skidLane <= fragLane;
                    skidData <= fragData;
                    skidStrb <= strobe;
                    skidLast <= fragLast;
                    skidFull <= 1'b1;
                    fragReady <= 1'b0;
                end
            end
        end
        else if (!req.valid)
        begin
            if (skidFull)
            begin
                // Old line went out with closeNow, the skid opens the next one
                openTag <= skidTag;
                openData[skidLane*PixelWidth +: PixelWidth] <= skidData;
                openStrb <= skidStrb;
                openOccupied <= 1'b1;
                skidFull <= 1'b0;
                fragReady <= !skidLast;
            end
            else
            begin
                // End of stream handed over
                openOccupied <= 1'b0;
                openStrb <= '0;
                fragReady <= 1'b1;
            end
        end
    end

    // A request is withdrawn only after the issuer took it
    assert property (@(posedge aclk) disable iff (!resetn)
        $fell(req.valid) |-> $past(req.take));

endmodule

/* source/LineRequestIf.sv */
`timescale 1ns/100ps

interface LineRequestIf import FramebufferPkg::*; ();
    // Level from the coalescer, held until taken
    logic                   valid;
    // One cycle pulse from the issuer
    logic                   take;
    logic [AddrWidth-1:0]   lineAddr;
    logic [StreamWidth-1:0] data;
    logic [StrbWidth-1:0]   strb;

    modport coalescer (
        output valid, lineAddr, data, strb,
        input  take
    );

    modport issuer (
        input  valid, lineAddr, data, strb,
        output take
    );

endinterface

/* source/OutstandingCounter.sv */
`timescale 1ns/100ps

module OutstandingCounter import FramebufferPkg::*;
(
    input  logic                aclk,
    input  logic                resetn,
    input  logic                issue,
    input  logic                bvalid,
    input  logic                bready,
    output logic                credit,
    output logic [IdWidth-1:0]  awid
);
    logic [CountWidth-1:0] count;
    logic                  respDone;

    assign respDone = bvalid && bready;
    assign credit = count < CountWidth'(MaxOutstanding);

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            count <= '0;
            awid <= '0;
        end
        else
        begin
            // ID of the write in flight on AW
            if (issue)
                awid <= awid + 1'b1;

            case ({issue, respDone})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // No response may arrive for a write that was never issued
    assert property (@(posedge aclk) disable iff (!resetn) respDone |-> count != '0);
    assert property (@(posedge aclk) disable iff (!resetn)
        count <= CountWidth'(MaxOutstanding));

endmodule

/* source/ScissorStrobeGen.sv */
`timescale 1ns/100ps

module ScissorStrobeGen import FramebufferPkg::*;
(
    input  logic                    confEnableScissor,
    input  logic [XBitWidth-1:0]    confScissorStartX,
    input  logic [YBitWidth-1:0]    confScissorStartY,
    input  logic [XBitWidth-1:0]    confScissorEndX,
    input  logic [YBitWidth-1:0]    confScissorEndY,
    input  logic [PixelBytes-1:0]   confMask,
    input  logic [XBitWidth-1:0]    xPos,
    input  logic [YBitWidth-1:0]    yPos,
    input  logic                    pixelStrobe,
    input  logic [LaneWidth-1:0]    laneSel,
    output logic [StrbWidth-1:0]    strobe
);
    logic                  insideX;
    logic                  insideY;
    logic                  scissorPass;
    logic [PixelBytes-1:0] pixelMask;

    // Start bounds are inclusive and end bounds exclusive
    assign insideX = (xPos >= confScissorStartX) && (xPos < confScissorEndX);
    assign insideY = (yPos >= confScissorStartY) && (yPos < confScissorEndY);

    assign scissorPass = !confEnableScissor || (insideX && insideY);

    // Colour mask applies only to fragments that survive the test
    assign pixelMask = (scissorPass && pixelStrobe) ? confMask : '0;

    // Lane 0 holds the low pixel of the word
    assign strobe = StrbWidth'(pixelMask) << (laneSel * PixelBytes);

endmodule

/* source/WriteIssueFsm.sv */
`timescale 1ns/100ps

module WriteIssueFsm import FramebufferPkg::*;
(
    input  logic                    aclk,
    input  logic                    resetn,

    input  logic [AddrWidth-1:0]    confAddr,
    input  logic                    credit,
    input  logic [IdWidth-1:0]      awid,
    output logic                    issue,

    LineRequestIf.issuer            req,

    output logic [AddrWidth-1:0]    awaddr,
    output logic                    awvalid,
    input  logic                    awready,

    output logic [StreamWidth-1:0]  wdata,
    output logic [StrbWidth-1:0]    wstrb,
    output logic                    wvalid,
    input  logic                    wready
);
    IssueState state;

    // Take a line only when both channels are free and a slot is left
    assign req.take = (state == Idle) && req.valid && credit;
    assign issue = req.take;

    assign awvalid = (state == AddrData) || (state == AddrOnly);
    assign wvalid = (state == AddrData) || (state == DataOnly);

    always_ff @(posedge aclk)
    begin
        if (!resetn)
            state <= Idle;
        else
        begin
            case (state)
                Idle:
                    if (req.take)
                        state <= AddrData;
                AddrData:
                    case ({awready, wready})
                        2'b11:   state <= Idle;
                        2'b10:   state <= DataOnly;
                        2'b01:   state <= AddrOnly;
                        default: state <= AddrData;
                    endcase
                AddrOnly:
                    if (awready)
                        state <= Idle;
                DataOnly:
                    if (wready)
                        state <= Idle;
                default:
                    state <= Idle;
            endcase
        end
    end

    // Beat payload is captured once per line
    always_ff @(posedge aclk)
    begin
        if (req.take)
        begin
            awaddr <= confAddr + req.lineAddr;
            wdata <= req.data;
            wstrb <= req.strb;
        end
    end

    // AW fields hold while the slave stalls, the ID comes from the counter
    assert property (@(posedge aclk) disable iff (!resetn)
        awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awid));

endmodule

/* sources.f */
source/FramebufferPkg.sv
source/LineRequestIf.sv
source/ScissorStrobeGen.sv
source/LineCoalescer.sv
source/WriteIssueFsm.sv
source/OutstandingCounter.sv
source/FramebufferWriter.sv
verification/FramebufferWriterTb.sv

/* verification/FramebufferWriterTb.sv */
`timescale 1ns/100ps

module FramebufferWriterTb import FramebufferPkg::*;
();
    // Six tests of at most about 500 cycles each plus margin
    localparam int CycleLimit = 4000;
    localparam int StressLength = 40;

    logic                   aclk = 1'b0;
    logic                   resetn = 1'b0;
    logic [AddrWidth-1:0]   confAddr = 32'h0004_0000;
    logic                   confEnableScissor = 1'b0;
    logic [XBitWidth-1:0]   confScissorStartX = '0;
    logic [YBitWidth-1:0]   confScissorStartY = '0;
    logic [XBitWidth-1:0]   confScissorEndX = '0;
    logic [YBitWidth-1:0]   confScissorEndY = '0;
    logic [PixelBytes-1:0]  confMask = 2'b11;
    logic                   fragValid = 1'b0;
    logic                   fragReady;
    logic [PixelWidth-1:0]  fragData = '0;
    logic                   fragStrobe = 1'b0;
    logic [AddrWidth-1:0]   fragAddr = '0;
    logic [XBitWidth-1:0]   fragXPos = '0;
    logic [YBitWidth-1:0]   fragYPos = '0;
    logic                   fragLast = 1'b0;
    logic [IdWidth-1:0]     awid;
    logic [AddrWidth-1:0]   awaddr;
    logic [7:0]             awlen;
    logic [2:0]             awsize;
    logic [1:0]             awburst;
    logic                   awvalid;
    logic                   awready = 1'b1;
    logic [StreamWidth-1:0] wdata;
    logic [StrbWidth-1:0]   wstrb;
    logic                   wlast;
    logic                   wvalid;
    logic                   wready = 1'b1;
    logic [IdWidth-1:0]     bid = '0;
    logic [1:0]             bresp = 2'b00;
    logic                   bvalid = 1'b0;
    logic                   bready;

    integer seed = 82;
    int     cycle = 0;
    logic   stress = 1'b0;
    int     awCount = 0;
    int     bCount = 0;
    int     testErrors = 0;
    int     totalErrors = 0;
    int     passed = 0;
    int     failed = 0;

    // Beats seen on the bus, and writes paired from them
    logic [AddrWidth-1:0]   awAddrQ[$];
    logic [IdWidth-1:0]     awIdQ[$];
    logic [12:0]            awBurstQ[$];
    logic [StreamWidth-1:0] wDataQ[$];
    logic [StrbWidth-1:0]   wStrbQ[$];
    logic                   wLastQ[$];
    logic [AddrWidth-1:0]   gotAddr[$];
    logic [IdWidth-1:0]     gotId[$];
    logic [12:0]            gotBurst[$];
    logic [StreamWidth-1:0] gotData[$];
    logic [StrbWidth-1:0]   gotStrb[$];
    logic                   gotLast[$];
    int                     bDue[$];
    logic [IdWidth-1:0]     bIdQ[$];

    // Reference model of the open line and its expected writes
    logic                   mOpen = 1'b0;
    int                     mTag = 0;
    logic [StreamWidth-1:0] mData = '0;
    logic [StrbWidth-1:0]   mStrb = '0;
    logic [IdWidth-1:0]     nextId = 8'd1;
    logic [AddrWidth-1:0]   expAddr[$];
    logic [IdWidth-1:0]     expId[$];
    logic [StreamWidth-1:0] expData[$];
    logic [StrbWidth-1:0]   expStrb[$];

    int                     stressIdx[StressLength];
    logic [PixelWidth-1:0]  stressData[StressLength];
    int                     stressX[StressLength];
    int                     stressY[StressLength];
    logic                   stressPix[StressLength];

    FramebufferWriter u_dut (.*);

    always #10 aclk = ~aclk;

    //////////////////////////////
    // Memory model and watchdog
    //////////////////////////////
    always @(posedge aclk)
    begin
        logic [31:0]        r;
        int                 delay;
        logic [IdWidth-1:0] id;
        cycle = cycle + 1;
        if (cycle > CycleLimit)
        begin
            $display("Timeout: the run did not finish within %0d cycles", CycleLimit);
            $display("=== FAIL ===");
            $finish;
        end
        else
        begin
            if (awvalid && awready)
            begin
                awAddrQ.push_back(awaddr);
                awIdQ.push_back(awid);
                awBurstQ.push_back({awlen, awsize, awburst});
                awCount++;
            end
            if (wvalid && wready)
            begin
                wDataQ.push_back(wdata);
                wStrbQ.push_back(wstrb);
                wLastQ.push_back(wlast);
            end
            // Address and data beats pair up in arrival order
            while (awAddrQ.size() != 0 && wDataQ.size() != 0)
            begin
                id = awIdQ.pop_front();
                gotAddr.push_back(awAddrQ.pop_front());
                gotId.push_back(id);
                gotBurst.push_back(awBurstQ.pop_front());
                gotData.push_back(wDataQ.pop_front());
                gotStrb.push_back(wStrbQ.pop_front());
                gotLast.push_back(wLastQ.pop_front());
                r = $random(seed);
                delay = stress ? int'(r[3:0]) : 1;
                bDue.push_back(cycle + delay);
                bIdQ.push_back(id);
            end
            if (bvalid && bready)
            begin
                void'(bDue.pop_front());
                void'(bIdQ.pop_front());
                bCount++;
            end
            assert (awCount - bCount <= MaxOutstanding)
            else
            begin
                $display("AW handshakes ran %0d ahead of B responses", awCount - bCount);
                testErrors++;
            end
            r = $random(seed);
            awready <= stress ? (r[1:0] != 2'b00) : 1'b1;
            wready <= stress ? (r[3:2] != 2'b00) : 1'b1;
            bvalid <= (bDue.size() != 0) && (cycle >= bDue[0]);
            bid <= (bIdQ.size() != 0) ? bIdQ[0] : '0;
        end
    end

    //////////////////////////////
    // Reference model
    //////////////////////////////
    function automatic logic [StrbWidth-1:0] expectedStrobe(input int idx, input int x,
        input int y, input logic pix);
        logic                 inRect;
        logic [StrbWidth-1:0] lanes;
        inRect = x >= int'(confScissorStartX) && x < int'(confScissorEndX)
            && y >= int'(confScissorStartY) && y < int'(confScissorEndY);
        lanes = (pix && (!confEnableScissor || inRect)) ? {2'b00, confMask} : 4'b0000;
        return idx[0] ? lanes << 2 : lanes;
    endfunction

    function automatic logic [StreamWidth-1:0] byteMask(input logic [StrbWidth-1:0] s);
        return {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
    endfunction

    task automatic closeModelLine();
        if (mOpen && mStrb != 4'b0000)
        begin
            expAddr.push_back(confAddr + 32'(mTag * 4));
            expId.push_back(nextId);
            expData.push_back(mData);
            expStrb.push_back(mStrb);
            nextId = nextId + 8'd1;
        end
        mOpen = 1'b0;
        mStrb = '0;
    endtask

    task automatic modelFrag(input logic [PixelWidth-1:0] data, input int idx, input int x,
        input int y, input logic pix, input logic last);
        if (mOpen && (idx >> 1) != mTag)
            closeModelLine();
        mOpen = 1'b1;
        mTag = idx >> 1;
        if (idx[0])
            mData[31:16] = data;
        else
            mData[15:0] = data;
        mStrb = mStrb | expectedStrobe(idx, x, y, pix);
        if (last)
            closeModelLine();
    endtask

    //////////////////////////////
    // Stimulus and checks
    //////////////////////////////
    // Called on a rising edge, returns on the edge that accepts the fragment
    task automatic sendFrag(input logic [PixelWidth-1:0] data, input int idx, input int x,
        input int y, input logic pix, input logic last);
        modelFrag(data, idx, x, y, pix, last);
        fragValid <= 1'b1;
        fragData <= data;
        fragAddr <= 32'(idx);
        fragXPos <= 11'(x);
        fragYPos <= 11'(y);
        fragStrobe <= pix;
        fragLast <= last;
        @(posedge aclk);
        while (!fragReady)
            @(posedge aclk);
    endtask

    task automatic endStream();
        fragValid <= 1'b0;
        fragLast <= 1'b0;
    endtask

    task automatic compareValue(input string name, input string field,
        input logic [31:0] expected, input logic [31:0] actual);
        assert (expected === actual)
        else
        begin
            $display("** Error %s: %s expected %h, actual %h", name, field, expected, actual);
            testErrors++;
        end
    endtask

    task automatic checkWrites(input string name);
        int i;
        while (gotAddr.size() < expAddr.size() || bDue.size() != 0 || !fragReady)
            @(posedge aclk);
        // Quiet window so that a stray write still shows up
        repeat (8) @(posedge aclk);
        compareValue(name, "write count", 32'(expAddr.size()), 32'(gotAddr.size()));
        for (i = 0; i < expAddr.size() && i < gotAddr.size(); i++)
        begin
            compareValue(name, "awaddr", expAddr[i], gotAddr[i]);
            compareValue(name, "awid", 32'(expId[i]), 32'(gotId[i]));
            // Every burst is one beat of four bytes with incrementing addresses
            compareValue(name, "awlen", 32'd0, 32'(gotBurst[i][12:5]));
            compareValue(name, "awsize", 32'd2, 32'(gotBurst[i][4:2]));
            compareValue(name, "awburst", 32'd1, 32'(gotBurst[i][1:0]));
            compareValue(name, "wlast", 32'd1, 32'(gotLast[i]));
            compareValue(name, "wstrb", 32'(expStrb[i]), 32'(gotStrb[i]));
            compareValue(name, "wdata", expData[i] & byteMask(expStrb[i]),
                gotData[i] & byteMask(expStrb[i]));
        end
        expAddr.delete();
        expId.delete();
        expData.delete();
        expStrb.delete();
        gotAddr.delete();
        gotId.delete();
        gotBurst.delete();
        gotData.delete();
        gotStrb.delete();
        gotLast.delete();
    endtask

    task automatic finishTest(input string name);
        if (testErrors == 0)
        begin
            $display("%s: ok", name);
            passed++;
        end
        else
        begin
            $display("%s: %0d errors", name, testErrors);
            failed++;
        end
        totalErrors += testErrors;
        testErrors = 0;
    endtask

    task automatic buildStressStream();
        int i;
        int idx;
        int step;
        idx = 300;
        for (i = 0; i < StressLength; i++)
        begin
            step = $random(seed) & 3;
            if (step == 3)
                step = 1;
            idx = idx + step;
            stressIdx[i] = idx;
            stressData[i] = 16'($random(seed));
            stressX[i] = $random(seed) & 31;
            stressY[i] = $random(seed) & 31;
            stressPix[i] = ($random(seed) & 7) != 0;
        end
    endtask

    //////////////////////////////
    // Directed tests
    //////////////////////////////
    task automatic resetState();
        @(posedge aclk);
        compareValue("resetState", "awvalid", 32'd0, 32'(awvalid));
        compareValue("resetState", "wvalid", 32'd0, 32'(wvalid));
        compareValue("resetState", "bready", 32'd1, 32'(bready));
        compareValue("resetState", "fragReady", 32'd1, 32'(fragReady));
        compareValue("resetState", "awid", 32'd0, 32'(awid));
        checkWrites("resetState");
        finishTest("resetState");
    endtask

    task automatic mergePair();
        @(posedge aclk);
        sendFrag(16'hA1B2, 10, 0, 0, 1'b1, 1'b0);
        sendFrag(16'hC3D4, 11, 1, 0, 1'b1, 1'b1);
        endStream();
        checkWrites("mergePair");
        finishTest("mergePair");
    endtask

    task automatic tagChanges();
        @(posedge aclk);
        sendFrag(16'h1111, 20, 0, 0, 1'b1, 1'b0);
        sendFrag(16'h2222, 23, 3, 0, 1'b1, 1'b0);
        sendFrag(16'h3333, 24, 4, 0, 1'b1, 1'b0);
        sendFrag(16'h4444, 25, 5, 0, 1'b1, 1'b1);
        endStream();
        checkWrites("tagChanges");
        finishTest("tagChanges");
    endtask

    // Middle line lies wholly on the end edge or outside the rectangle
    task automatic scissorStream();
        @(posedge aclk);
        sendFrag(16'h0A0A, 40, 10, 10, 1'b1, 1'b0);
        sendFrag(16'h0B0B, 41, 20, 15, 1'b1, 1'b0);
        sendFrag(16'h0C0C, 42, 15, 20, 1'b1, 1'b0);
        sendFrag(16'h0D0D, 43, 5, 15, 1'b1, 1'b0);
        sendFrag(16'h0E0E, 44, 19, 19, 1'b1, 1'b0);
        sendFrag(16'h0F0F, 45, 9, 12, 1'b1, 1'b1);
        endStream();
    endtask

    task automatic scissorTest();
        confEnableScissor <= 1'b1;
        confScissorStartX <= 11'd10;
        confScissorStartY <= 11'd10;
        confScissorEndX <= 11'd20;
        confScissorEndY <= 11'd20;
        scissorStream();
        checkWrites("scissorTest");
        confEnableScissor <= 1'b0;
        scissorStream();
        checkWrites("scissorTest");
        finishTest("scissorTest");
    endtask

    task automatic colourMaskTest();
        confMask <= 2'b01;
        @(posedge aclk);
        sendFrag(16'h5566, 60, 0, 0, 1'b1, 1'b0);
        sendFrag(16'h7788, 61, 1, 0, 1'b1, 1'b1);
        endStream();
        checkWrites("colourMaskTest");
        confMask <= 2'b10;
        @(posedge aclk);
        sendFrag(16'h99AA, 62, 2, 0, 1'b1, 1'b0);
        sendFrag(16'hBBCC, 63, 3, 0, 1'b1, 1'b1);
        endStream();
        checkWrites("colourMaskTest");
        confMask <= 2'b11;
        finishTest("colourMaskTest");
    endtask

    task automatic backPressure();
        int i;
        stress = 1'b1;
        confEnableScissor <= 1'b1;
        confScissorStartX <= 11'd4;
        confScissorStartY <= 11'd4;
        confScissorEndX <= 11'd28;
        confScissorEndY <= 11'd28;
        @(posedge aclk);
        for (i = 0; i < StressLength; i++)
            sendFrag(stressData[i], stressIdx[i], stressX[i], stressY[i], stressPix[i],
                i == StressLength - 1);
        endStream();
        checkWrites("backPressure");
        stress = 1'b0;
        confEnableScissor <= 1'b0;
        finishTest("backPressure");
    endtask

    initial
    begin
        buildStressStream();
        repeat (3) @(posedge aclk);
        resetn <= 1'b1;
        resetState();
        mergePair();
        tagChanges();
        scissorTest();
        colourMaskTest();
        backPressure();
        $display("Tests: %0d passed, %0d failed, %0d errors", passed, failed, totalErrors);
        if (failed == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule
